//--- include/mmap_defines.svh
`ifndef MMAP_DEFINES_SVH
`define MMAP_DEFINES_SVH

// address and beat geometry
`define MMAP_ADDR_W 64
`define MMAP_DATA_W 512
`define MMAP_BYTES_LOG 6

// AXI length field and idle counter widths
`define MMAP_BURST_LEN_W 8
`define MMAP_WAIT_W 4

// burst inference limits
`define MMAP_MAX_WAIT 3
// length field value, so 16 beats
`define MMAP_MAX_BURST_LEN 15

// queue sizing
`define MMAP_FIFO_DEPTH 32
`define MMAP_FIFO_DEPTH_LOG 5

// fixed AR fields
`define MMAP_AXI_BURST_INCR 1
`define MMAP_AXI_CACHE 4'b0011

`endif

//--- rtl/mmap_pkg.sv
`include "mmap_defines.svh"

package mmap_pkg;

  // byte address on the AXI side
  typedef logic [`MMAP_ADDR_W-1:0] addr_t;

  // one beat of read data
  typedef logic [`MMAP_DATA_W-1:0] data_t;

  // beats minus one, as carried in arlen
  typedef logic [`MMAP_BURST_LEN_W-1:0] burst_len_t;

  // idle cycles seen while a burst is open
  typedef logic [`MMAP_WAIT_W-1:0] wait_t;

  // one AR request
  typedef struct packed {
    burst_len_t len;
    addr_t      addr;
  } burst_req_t;

endpackage

//--- rtl/mmap_fifo.sv
`include "mmap_defines.svh"

module mmap_fifo #(
  parameter type T = logic
) (
  input  logic clk,
  input  logic rst_n,
  // push side
  input  T     din,
  input  logic write,
  output logic full_n,
  // pop side
  output T     dout,
  input  logic read,
  output logic empty_n
);

  localparam logic [`MMAP_FIFO_DEPTH_LOG:0] full_count = `MMAP_FIFO_DEPTH;

  T mem [`MMAP_FIFO_DEPTH];

  logic [`MMAP_FIFO_DEPTH_LOG-1:0] wr_ptr;
  logic [`MMAP_FIFO_DEPTH_LOG-1:0] rd_ptr;
  logic [`MMAP_FIFO_DEPTH_LOG:0]   count;
  logic                            do_push;
  logic                            do_pop;

  function automatic logic [`MMAP_FIFO_DEPTH_LOG-1:0] next_ptr(
    input logic [`MMAP_FIFO_DEPTH_LOG-1:0] ptr
  );
    if (ptr == `MMAP_FIFO_DEPTH_LOG'(`MMAP_FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // requests against a full or empty queue are dropped here
  assign do_push = write && full_n;
  assign do_pop  = read && empty_n;

  assign full_n  = (count != full_count);
  assign empty_n = (count != '0);

  // head entry is always visible
  assign dout = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- rtl/read_addr_intake.sv
`include "mmap_defines.svh"

module read_addr_intake (
  input  logic              clk,
  input  logic              rst_n,
  // base of the memory region
  input  mmap_pkg::addr_t   offset,
  // word indices from the user
  input  mmap_pkg::addr_t   read_addr_din,
  input  logic              read_addr_write,
  output logic              read_addr_full_n,
  // byte addresses to the burst detector
  output mmap_pkg::addr_t   addr_dout,
  output logic              addr_empty_n,
  input  logic              addr_read
);

  mmap_pkg::addr_t byte_addr;

  // word index to byte address, one beat per index
  assign byte_addr = offset + (read_addr_din << `MMAP_BYTES_LOG);

  mmap_fifo #(
    .T(mmap_pkg::addr_t)
  ) addr_fifo (
    .clk    (clk),
    .rst_n  (rst_n),
    .din    (byte_addr),
    .write  (read_addr_write),
    .full_n (read_addr_full_n),
    .dout   (addr_dout),
    .read   (addr_read),
    .empty_n(addr_empty_n)
  );

endmodule

//--- rtl/burst_detect.sv
`include "mmap_defines.svh"

module burst_detect (
  input  logic                 clk,
  input  logic                 rst_n,
  // single byte addresses in
  input  mmap_pkg::addr_t      addr_dout,
  input  logic                 addr_empty_n,
  output logic                 addr_read,
  // merged bursts out
  output mmap_pkg::burst_req_t burst_din,
  output logic                 burst_write,
  input  logic                 burst_full_n
);

  localparam mmap_pkg::addr_t      beat_bytes = mmap_pkg::addr_t'(1) << `MMAP_BYTES_LOG;
  localparam mmap_pkg::burst_len_t max_len    = `MMAP_MAX_BURST_LEN;
  localparam mmap_pkg::wait_t      max_wait   = `MMAP_MAX_WAIT;

  // open burst
  logic                 open;
  mmap_pkg::addr_t      start_addr;
  mmap_pkg::burst_len_t cur_len;
  mmap_pkg::addr_t      next_addr;
  mmap_pkg::wait_t      wait_cnt;

  logic contig;
  logic len_full;
  logic timed_out;
  logic extend;
  logic close;
  logic emit;
  logic start_new;

  assign contig    = addr_empty_n && (addr_dout == next_addr);
  assign len_full  = (cur_len == max_len);
  assign timed_out = !addr_empty_n && (wait_cnt == max_wait);

  // grow the burst while the head address follows on
  assign extend = open && contig && !len_full;

  // break in the run, 16 beats reached, or idle too long
  assign close = open && !extend && (len_full || addr_empty_n || timed_out);

  // a closed burst holds until the burst queue has room
  assign emit = close && burst_full_n;

  // the address that broke the run opens the next burst in the same cycle
  assign start_new = addr_empty_n && (!open || emit);

  assign addr_read   = extend || start_new;
  assign burst_write = emit;
  assign burst_din   = '{len: cur_len, addr: start_addr};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      open     <= 1'b0;
      cur_len  <= '0;
      wait_cnt <= '0;
    end else if (start_new) begin
      open     <= 1'b1;
      cur_len  <= '0;
      wait_cnt <= '0;
    end else if (extend) begin
      cur_len  <= cur_len + 1'b1;
      wait_cnt <= '0;
    end else if (emit) begin
      open     <= 1'b0;
      wait_cnt <= '0;
    end else if (open && !addr_empty_n && wait_cnt != max_wait) begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  // start and expected next address
  always_ff @(posedge clk) begin
    if (start_new) begin
      start_addr <= addr_dout;
      next_addr  <= addr_dout + beat_bytes;
    end else if (extend) begin
      next_addr <= next_addr + beat_bytes;
    end
  end

endmodule

//--- rtl/axi_read_port.sv
`include "mmap_defines.svh"

module axi_read_port (
  input  logic                 clk,
  input  logic                 rst_n,
  // bursts from the detector
  input  mmap_pkg::burst_req_t burst_din,
  input  logic                 burst_write,
  output logic                 burst_full_n,
  // AR channel
  output logic                 arvalid,
  input  logic                 arready,
  output mmap_pkg::addr_t      araddr,
  output mmap_pkg::burst_len_t arlen,
  output logic [2:0]           arsize,
  output logic [1:0]           arburst,
  output logic [3:0]           arcache,
  // R channel
  input  logic                 rvalid,
  output logic                 rready,
  input  mmap_pkg::data_t      rdata,
  // read data to the user
  output mmap_pkg::data_t      read_data_dout,
  input  logic                 read_data_read,
  output logic                 read_data_empty_n
);

  mmap_pkg::burst_req_t burst_head;

  mmap_fifo #(
    .T(mmap_pkg::burst_req_t)
  ) burst_fifo (
    .clk    (clk),
    .rst_n  (rst_n),
    .din    (burst_din),
    .write  (burst_write),
    .full_n (burst_full_n),
    .dout   (burst_head),
    .read   (arready),
    .empty_n(arvalid)
  );

  // head burst drives AR, fixed fields come from the defines
  assign araddr  = burst_head.addr;
  assign arlen   = burst_head.len;
  assign arsize  = 3'(`MMAP_BYTES_LOG);
  assign arburst = 2'(`MMAP_AXI_BURST_INCR);
  assign arcache = `MMAP_AXI_CACHE;

  // rready follows free space in the data queue
  mmap_fifo #(
    .T(mmap_pkg::data_t)
  ) data_fifo (
    .clk    (clk),
    .rst_n  (rst_n),
    .din    (rdata),
    .write  (rvalid),
    .full_n (rready),
    .dout   (read_data_dout),
    .read   (read_data_read),
    .empty_n(read_data_empty_n)
  );

endmodule

//--- rtl/async_mmap_read.sv
module async_mmap_read (
  input  logic                 clk,
  input  logic                 rst_n,
  input  mmap_pkg::addr_t      offset,
  // word indices in
  input  mmap_pkg::addr_t      read_addr_din,
  input  logic                 read_addr_write,
  output logic                 read_addr_full_n,
  // read data out
  output mmap_pkg::data_t      read_data_dout,
  input  logic                 read_data_read,
  output logic                 read_data_empty_n,
  // AR channel
  output logic                 arvalid,
  input  logic                 arready,
  output mmap_pkg::addr_t      araddr,
  output mmap_pkg::burst_len_t arlen,
  output logic [2:0]           arsize,
  output logic [1:0]           arburst,
  output logic [3:0]           arcache,
  // R channel
  input  logic                 rvalid,
  output logic                 rready,
  input  mmap_pkg::data_t      rdata
);

  // intake to detector
  mmap_pkg::addr_t      addr_dout;
  logic                 addr_empty_n;
  logic                 addr_read;

  // detector to AXI port
  mmap_pkg::burst_req_t burst_din;
  logic                 burst_write;
  logic                 burst_full_n;

  read_addr_intake intake (
    .clk             (clk),
    .rst_n           (rst_n),
    .offset          (offset),
    .read_addr_din   (read_addr_din),
    .read_addr_write (read_addr_write),
    .read_addr_full_n(read_addr_full_n),
    .addr_dout       (addr_dout),
    .addr_empty_n    (addr_empty_n),
    .addr_read       (addr_read)
  );

  burst_detect detect (
    .clk         (clk),
    .rst_n       (rst_n),
    .addr_dout   (addr_dout),
    .addr_empty_n(addr_empty_n),
    .addr_read   (addr_read),
    .burst_din   (burst_din),
    .burst_write (burst_write),
    .burst_full_n(burst_full_n)
  );

  axi_read_port port (
    .clk              (clk),
    .rst_n            (rst_n),
    .burst_din        (burst_din),
    .burst_write      (burst_write),
    .burst_full_n     (burst_full_n),
    .arvalid          (arvalid),
    .arready          (arready),
    .araddr           (araddr),
    .arlen            (arlen),
    .arsize           (arsize),
    .arburst          (arburst),
    .arcache          (arcache),
    .rvalid           (rvalid),
    .rready           (rready),
    .rdata            (rdata),
    .read_data_dout   (read_data_dout),
    .read_data_read   (read_data_read),
    .read_data_empty_n(read_data_empty_n)
  );

endmodule

//--- sim/async_mmap_read_asserts.sv
`include "mmap_defines.svh"

module async_mmap_read_asserts (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 arvalid,
  input logic                 arready,
  input mmap_pkg::addr_t      araddr,
  input mmap_pkg::burst_len_t arlen,
  input logic                 read_data_empty_n
);

  timeunit 1ns;
  timeprecision 1ps;

  // failed assertions so far, watched from the testbench
  int unsigned fail_count = 0;

  // a waiting AR request holds its fields until arready
  ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
    arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen))
    else begin
      $error("AR request changed before arready");
      fail_count++;
    end

  // never more than 16 beats per burst
  ar_len_limit: assert property (@(posedge clk) disable iff (!rst_n)
    arvalid |-> arlen <= `MMAP_MAX_BURST_LEN)
    else begin
      $error("arlen above the burst limit");
      fail_count++;
    end

  // queues come out of reset empty
  empty_after_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> !arvalid && !read_data_empty_n)
    else begin
      $error("arvalid or read_data_empty_n high right after reset");
      fail_count++;
    end

endmodule

//--- sim/async_mmap_read_tb.sv
`include "mmap_defines.svh"

module async_mmap_read_tb;

  timeunit 1ns;
  timeprecision 1ps;

  typedef mmap_pkg::addr_t      addr_q_t[$];
  typedef mmap_pkg::burst_req_t burst_q_t[$];

  localparam mmap_pkg::addr_t base_offset = 64'h0000_0040_0000_0000;

  logic                 clk;
  logic                 rst_n;
  mmap_pkg::addr_t      offset;
  mmap_pkg::addr_t      read_addr_din;
  logic                 read_addr_write;
  logic                 read_addr_full_n;
  mmap_pkg::data_t      read_data_dout;
  logic                 read_data_read;
  logic                 read_data_empty_n;
  logic                 arvalid;
  logic                 arready;
  mmap_pkg::addr_t      araddr;
  mmap_pkg::burst_len_t arlen;
  logic [2:0]           arsize;
  logic [1:0]           arburst;
  logic [3:0]           arcache;
  logic                 rvalid;
  logic                 rready;
  mmap_pkg::data_t      rdata;

  // expected AR requests and beat addresses, in push order
  burst_q_t exp_bursts;
  addr_q_t  exp_addrs;
  // bursts accepted by the slave model that still owe data
  burst_q_t ar_pending;
  int       beat_idx;
  logic     r_fire;
  int       pushed;

  async_mmap_read uut (.*);

  bind async_mmap_read async_mmap_read_asserts protocol_checks (.*);

  // memory contents seen through the slave model
  function automatic mmap_pkg::data_t mem_word(mmap_pkg::addr_t addr);
    mmap_pkg::data_t w;
    for (int i = 0; i < `MMAP_DATA_W / 64; i++) begin
      w[i*64 +: 64] = ({addr[31:0], addr[63:32]} ^ (64'h9e37_79b9_7f4a_7c15 * 64'(i + 1))) + addr;
    end
    return w;
  endfunction

  // offset plus 64 bytes per word index
  function automatic mmap_pkg::addr_t byte_addr(mmap_pkg::addr_t idx);
    return base_offset + idx * 64;
  endfunction

  // contiguous runs of at most 16 beats, one burst each
  function automatic burst_q_t expected_bursts(addr_q_t idx);
    burst_q_t             res;
    mmap_pkg::burst_req_t cur;
    for (int i = 0; i < idx.size(); i++) begin
      if (i > 0 && idx[i] == idx[i-1] + 1 && cur.len != `MMAP_MAX_BURST_LEN) begin
        cur.len = cur.len + 1'b1;
      end else begin
        if (i > 0) begin
          res.push_back(cur);
        end
        cur.addr = byte_addr(idx[i]);
        cur.len  = '0;
      end
    end
    if (idx.size() > 0) begin
      res.push_back(cur);
    end
    return res;
  endfunction

  task automatic fail_now(string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_burst(mmap_pkg::burst_req_t actual, mmap_pkg::burst_req_t expected);
    if (actual !== expected) begin
      fail_now($sformatf("Mismatch at %0t: AR addr %h len %0d, expected addr %h len %0d",
        $time, actual.addr, actual.len, expected.addr, expected.len));
    end
  endtask

  task automatic check_attr(logic [2:0] size, logic [1:0] burst, logic [3:0] cache);
    if (size !== 3'd6 || burst !== 2'd1 || cache !== 4'd3) begin
      fail_now($sformatf("Mismatch at %0t: arsize %0d arburst %0d arcache %0d, expected 6 1 3",
        $time, size, burst, cache));
    end
  endtask

  task automatic check_beat(mmap_pkg::data_t actual, mmap_pkg::data_t expected,
                            mmap_pkg::addr_t addr);
    if (actual !== expected) begin
      fail_now($sformatf("Mismatch at %0t: beat for %h low word %h, expected %h",
        $time, addr, actual[63:0], expected[63:0]));
    end
  endtask

  task automatic check_flag(string name, logic actual, logic expected);
    if (actual !== expected) begin
      fail_now($sformatf("Mismatch at %0t: %s is %b, expected %b",
        $time, name, actual, expected));
    end
  endtask

  // one index per cycle, then idle until every burst of the run is on AR
  task automatic push_run(addr_q_t idx);
    burst_q_t bursts;
    bursts = expected_bursts(idx);
    foreach (bursts[i]) begin
      exp_bursts.push_back(bursts[i]);
    end
    foreach (idx[i]) begin
      exp_addrs.push_back(byte_addr(idx[i]));
    end
    foreach (idx[i]) begin
      if (!read_addr_full_n) begin
        fail_now("address queue was full in the middle of a run");
      end
      read_addr_din   = idx[i];
      read_addr_write = 1'b1;
      pushed++;
      @(posedge clk);
      #1;
    end
    read_addr_write = 1'b0;
    repeat (8) @(posedge clk);
    // the last burst only closes through the idle timeout
    while (exp_bursts.size() != 0) begin
      @(posedge clk);
    end
    #1;
  endtask

  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

  initial begin : stimulus
    addr_q_t run;
    rst_n           = 1'b0;
    offset          = base_offset;
    read_addr_din   = '0;
    read_addr_write = 1'b0;
    pushed          = 0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_flag("arvalid", arvalid, 1'b0);
    check_flag("read_data_empty_n", read_data_empty_n, 1'b0);
    check_flag("read_addr_full_n", read_addr_full_n, 1'b1);
    check_flag("rready", rready, 1'b1);
    // single runs of 1 to 16 beats
    for (int n = 1; n <= 16; n++) begin
      run = {};
      for (int i = 0; i < n; i++) begin
        run.push_back(mmap_pkg::addr_t'(n * 1000 + i));
      end
      push_run(run);
    end
    // 40 beats split at the length limit
    run = {};
    for (int i = 0; i < 40; i++) begin
      run.push_back(mmap_pkg::addr_t'(40000 + i));
    end
    push_run(run);
    // breaks in contiguity, ending with an isolated index
    run = {};
    for (int i = 0; i < 5; i++) begin
      run.push_back(mmap_pkg::addr_t'(3000 + i));
    end
    for (int i = 0; i < 10; i++) begin
      run.push_back(mmap_pkg::addr_t'(5000 + i));
    end
    run.push_back(mmap_pkg::addr_t'(7000));
    push_run(run);
    // descending indices, every one a new burst
    run = {};
    for (int i = 0; i < 10; i++) begin
      run.push_back(mmap_pkg::addr_t'(20000 - 3 * i));
    end
    push_run(run);
    // long run under the same random stalls
    run = {};
    for (int i = 0; i < 100; i++) begin
      run.push_back(mmap_pkg::addr_t'(30000 + i));
    end
    push_run(run);
    while (exp_addrs.size() != 0 || exp_bursts.size() != 0) begin
      @(posedge clk);
    end
    repeat (20) @(posedge clk);
    #1;
    check_flag("arvalid at the end", arvalid, 1'b0);
    check_flag("read_data_empty_n at the end", read_data_empty_n, 1'b0);
    if (uut.protocol_checks.fail_count == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      fail_now("a protocol assertion failed near the end of the run");
    end
  end

  // AXI slave and user pop side, random stalls throughout
  initial begin : axi_slave
    void'($urandom(32'hdcfb));
    arready        = 1'b0;
    rvalid         = 1'b0;
    rdata          = '0;
    read_data_read = 1'b0;
    beat_idx       = 0;
    @(posedge rst_n);
    forever begin
      @(posedge clk);
      #1;
      if (r_fire) begin
        if (beat_idx == int'(ar_pending[0].len)) begin
          void'(ar_pending.pop_front());
          beat_idx = 0;
        end else begin
          beat_idx++;
        end
      end
      arready = ($urandom % 4) != 0;
      // a presented beat stays until rready takes it
      if (!rvalid || r_fire) begin
        rvalid = 1'b0;
        if (ar_pending.size() != 0 && ($urandom % 3) != 0) begin
          rvalid = 1'b1;
          rdata  = mem_word(ar_pending[0].addr
                            + (mmap_pkg::addr_t'(beat_idx) << `MMAP_BYTES_LOG));
        end
      end
      read_data_read = ($urandom % 2) != 0;
    end
  end

  // handshakes sampled half a cycle before the edge that completes them
  initial begin : compare
    mmap_pkg::burst_req_t seen;
    mmap_pkg::addr_t      addr;
    r_fire = 1'b0;
    forever begin
      @(negedge clk);
      r_fire = rst_n && rvalid && rready;
      if (rst_n && arvalid && arready) begin
        seen = '{len: arlen, addr: araddr};
        check_attr(arsize, arburst, arcache);
        if (exp_bursts.size() == 0) begin
          fail_now("AR request issued with no burst expected");
        end
        check_burst(seen, exp_bursts.pop_front());
        ar_pending.push_back(seen);
      end
      if (rst_n && read_data_empty_n && read_data_read) begin
        if (exp_addrs.size() == 0) begin
          fail_now("read data popped with no beat expected");
        end
        addr = exp_addrs.pop_front();
        check_beat(read_data_dout, mem_word(addr), addr);
      end
      if (uut.protocol_checks.fail_count != 0) begin
        fail_now("a protocol assertion failed");
      end
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles <= 200 * pushed + 1000) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: traffic still pending after %0d cycles", cycles);
    $display("Checks failed");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- build.f
+incdir+include
rtl/mmap_pkg.sv
rtl/mmap_fifo.sv
rtl/read_addr_intake.sv
rtl/burst_detect.sv
rtl/axi_read_port.sv
rtl/async_mmap_read.sv
sim/async_mmap_read_asserts.sv
sim/async_mmap_read_tb.sv

//--- Bender.yml
package:
  name: async_mmap_read

sources:
  - include_dirs:
      - include
    files:
      - rtl/mmap_pkg.sv
      - rtl/mmap_fifo.sv
      - rtl/read_addr_intake.sv
      - rtl/burst_detect.sv
      - rtl/axi_read_port.sv
      - rtl/async_mmap_read.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/async_mmap_read_asserts.sv
      - sim/async_mmap_read_tb.sv
